/* eg_atten.sv */
// output attenuation store, level plus 8*tl clipped at LVL_MAX
// captured on the same edge that writes the level
`timescale 1ns/1ns
`default_nettype none

module eg_atten import eg_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic [SLOT_W-1:0] p1_slot,
	input  logic [6:0]        p1_tl,
	input  logic [LVL_W-1:0]  level_new,
	input  logic [SLOT_W-1:0] out_sel,
	output logic [LVL_W-1:0]  out_val
);

	logic [LVL_W-1:0] out_mem [NUM_SLOTS];
	logic [LVL_W:0]   sum;

	assign sum = level_new + {p1_tl, 3'b000}; // tl step is 8 level units

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_SLOTS; i++)
				out_mem[i] <= LVL_MAX;
		end else begin
			out_mem[p1_slot] <= (sum > LVL_MAX) ? LVL_MAX : sum[LVL_W-1:0];
		end
	end

	assign out_val = out_mem[out_sel]; // host readback

endmodule

`default_nettype wire

/* eg_ctrl.sv */
// envelope control, stage 0 of the slot pipeline
// one slot per clock, the envelope counter steps every three rotations
// settings and level_now must be combinational reads for the current slot
// release rate enters the pipeline as 2*rrate+1
`timescale 1ns/1ns
`default_nettype none

module eg_ctrl import eg_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic [4:0]          keycode,
	input  logic [1:0]          ks,
	input  logic [4:0]          arate,
	input  logic [4:0]          rate1,
	input  logic [4:0]          rate2,
	input  logic [3:0]          rrate,
	input  logic [3:0]          d1l,
	input  logic [6:0]          tl,
	input  logic                keyon,
	input  logic [LVL_W-1:0]    level_now,
	output logic [SLOT_W-1:0]   slot,
	output logic [SLOT_W-1:0]   p1_slot,
	output eg_phase_t           p1_phase,
	output logic [4:0]          p1_cfg,
	output logic [4:0]          p1_keycode,
	output logic [1:0]          p1_ks,
	output logic                p1_instant,
	output logic [6:0]          p1_tl,
	output logic [EG_CNT_W-1:0] eg_cnt
);

	eg_phase_t  phase_mem [NUM_SLOTS];
	logic       kon_last  [NUM_SLOTS];
	logic [1:0] div3;
	logic       wrap;
	logic       key_rise;
	logic       key_fall;
	logic [4:0] d1level;
	eg_phase_t  phase_nxt;
	logic [4:0] cfg_nxt;

	assign wrap     = (slot == SLOT_W'(NUM_SLOTS - 1));
	assign key_rise = keyon && !kon_last[slot];
	assign key_fall = !keyon && kon_last[slot];
	assign d1level  = (d1l == 4'd15) ? 5'd16 : {1'b0, d1l}; // top step is 48 dB

	always_comb begin
		phase_nxt = phase_mem[slot];
		if (key_fall) begin
			phase_nxt = PH_RELEASE;
		end else if (key_rise) begin
			phase_nxt = PH_ATTACK;
		end else begin
			case (phase_mem[slot])
				PH_ATTACK: begin
					if (level_now == '0)
						phase_nxt = PH_DECAY1;
				end
				PH_DECAY1: begin
					if (level_now[LVL_W-1:5] >= d1level)
						phase_nxt = PH_DECAY2;
				end
				default: ; // decay 2 and release hold
			endcase
		end
		case (phase_nxt)
			PH_ATTACK:  cfg_nxt = arate;
			PH_DECAY1:  cfg_nxt = rate1;
			PH_DECAY2:  cfg_nxt = rate2;
			default:    cfg_nxt = {rrate, 1'b1};
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			slot   <= '0;
			div3   <= '0;
			eg_cnt <= '0;
		end else begin
			slot <= wrap ? '0 : slot + 1'b1;
			if (wrap) begin
				if (div3 == 2'd2) begin
					div3   <= '0;
					eg_cnt <= eg_cnt + 1'b1;
				end else begin
					div3 <= div3 + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_SLOTS; i++) begin
				phase_mem[i] <= PH_RELEASE;
				kon_last[i]  <= 1'b0;
			end
			p1_slot    <= '0;
			p1_phase   <= PH_RELEASE;
			p1_cfg     <= '0;
			p1_keycode <= '0;
			p1_ks      <= '0;
			p1_instant <= 1'b0;
			p1_tl      <= '0;
		end else begin
			phase_mem[slot] <= phase_nxt;
			kon_last[slot]  <= keyon;
			p1_slot    <= slot;
			p1_phase   <= phase_nxt;
			p1_cfg     <= cfg_nxt;
			p1_keycode <= keycode;
			p1_ks      <= ks;
			p1_instant <= key_rise && (arate == 5'd31);
			p1_tl      <= tl;
		end
	end

	// eg_rate relies on the counter being stable within a rotation
	a_cnt_on_wrap: assert property (@(posedge clk) disable iff (rst)
		$changed(eg_cnt) |-> $past(slot) == SLOT_W'(NUM_SLOTS - 1));

endmodule

`default_nettype wire

/* eg_level.sv */
// per-slot attenuation levels, written at the end of stage 1
// level_now is read for the stage 0 slot, never the one being written
// attack drops by about level/16 times step_size, decay saturates at LVL_MAX
`timescale 1ns/1ns
`default_nettype none

module eg_level import eg_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic [SLOT_W-1:0] p1_slot,
	input  eg_phase_t         p1_phase,
	input  logic              p1_instant,
	input  logic              step_en,
	input  logic [STEP_W-1:0] step_size,
	input  logic [SLOT_W-1:0] slot,
	output logic [LVL_W-1:0]  level_now,
	output logic [LVL_W-1:0]  level_new
);

	logic [LVL_W-1:0] level_mem [NUM_SLOTS];
	logic             was_attack [NUM_SLOTS]; // phase seen on the previous visit
	logic [LVL_W-1:0] level_old;
	logic [LVL_W:0]   drop;
	logic [LVL_W-1:0] ar_level;
	logic [LVL_W:0]   dec_sum;

	assign level_now = level_mem[slot];
	assign level_old = level_mem[p1_slot];

	assign drop     = (level_old[LVL_W-1:4] + 1'b1) * step_size;
	assign ar_level = (drop >= level_old) ? '0 : level_old - drop[LVL_W-1:0];
	assign dec_sum  = level_old + step_size;

	always_comb begin
		level_new = level_old;
		if (p1_phase == PH_ATTACK) begin
			if (p1_instant)
				level_new = '0; // attack rate 31 at key-on
			else if (step_en && level_old != '0)
				level_new = (step_size == STEP_FULL) ? '0 : ar_level;
		end else if (step_en) begin
			level_new = (dec_sum > LVL_MAX) ? LVL_MAX : dec_sum[LVL_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_SLOTS; i++) begin
				level_mem[i]  <= LVL_MAX;
				was_attack[i] <= 1'b0;
			end
		end else begin
			level_mem[p1_slot]  <= level_new;
			was_attack[p1_slot] <= (p1_phase == PH_ATTACK);
		end
	end

	// eg_ctrl may only end attack into decay 1 once the level reached 0
	a_attack_down: assert property (@(posedge clk) disable iff (rst)
		p1_phase == PH_DECAY1 && was_attack[p1_slot] |-> level_old == '0);

endmodule

`default_nettype wire

/* eg_pkg.sv */
// shared constants and encodings for the envelope generator
// slot count must stay a power of two, the slot counter wraps on SLOT_W bits
// levels are attenuation, 0 loudest and LVL_MAX silent
`default_nettype none

package eg_pkg;

	localparam int NUM_SLOTS = 8;
	localparam int SLOT_W    = 3;

	localparam int LVL_W = 10;
	localparam logic [LVL_W-1:0] LVL_MAX = {LVL_W{1'b1}};

	localparam int RATE_W   = 6;
	localparam int EG_CNT_W = 15; // global envelope counter

	// step size, decay adds it, attack scales level/16 by it
	localparam int STEP_W = 4;
	localparam logic [STEP_W-1:0] STEP_FULL = {STEP_W{1'b1}}; // attack jumps to 0

	localparam int WB_ADR_W = 6;
	localparam int WB_DAT_W = 16;

	typedef enum logic [1:0] {
		PH_ATTACK,
		PH_DECAY1,
		PH_DECAY2,
		PH_RELEASE
	} eg_phase_t;

	// offset inside a slot's block of eight addresses
	typedef enum logic [2:0] {
		REG_KEYCODE, // ks in 6..5, keycode in 4..0
		REG_ARATE,
		REG_RATE1,
		REG_RATE2,
		REG_RREL,    // d1l in 7..4, release rate in 3..0
		REG_TL,
		REG_KEYON,
		REG_OUT      // read only
	} eg_reg_t;

endpackage

`default_nettype wire

/* eg_rate.sv */
// rate scaling and step decision, combinational in stage 1
// keeps one counter bit per slot, a step needs that bit to toggle between visits
// step_size codes the amount, STEP_FULL asks attack to jump to 0
`timescale 1ns/1ns
`default_nettype none

module eg_rate import eg_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic [SLOT_W-1:0]   p1_slot,
	input  eg_phase_t           p1_phase,
	input  logic [4:0]          p1_cfg,
	input  logic [4:0]          p1_keycode,
	input  logic [1:0]          p1_ks,
	input  logic [EG_CNT_W-1:0] eg_cnt,
	output logic                step_en,
	output logic [STEP_W-1:0]   step_size
);

	logic              cnt_last [NUM_SLOTS];
	logic              attack;
	logic [RATE_W:0]   pre_rate;
	logic [RATE_W-1:0] rate;
	logic [3:0]        base;
	logic [3:0]        sh;
	logic [2:0]        cnt_win;
	logic [7:0]        pattern;
	logic              step;
	logic              tick;

	assign attack   = (p1_phase == PH_ATTACK);
	assign pre_rate = {1'b0, p1_cfg, 1'b0} + (p1_keycode >> (2'd3 - p1_ks));

	always_comb begin
		if (p1_cfg == '0)
			rate = '0;
		else if (pre_rate[RATE_W])
			rate = '1; // clamp at 63
		else
			rate = pre_rate[RATE_W-1:0];
	end

	// faster rates look at lower counter bits, attack one bit lower still
	assign base    = attack ? 4'd11 : 4'd12;
	assign sh      = (rate[5:2] >= base) ? 4'd0 : base - rate[5:2];
	assign cnt_win = eg_cnt[sh +: 3];
	assign tick    = cnt_win[0] != cnt_last[p1_slot];

	always_comb begin
		if (rate[5:4] == 2'b11) begin
			if (rate[5:2] == 4'hf && attack) begin
				pattern = 8'b11111111;
			end else begin
				case (rate[1:0])
					2'd0: pattern = 8'b00000000;
					2'd1: pattern = 8'b10001000;
					2'd2: pattern = 8'b10101010;
					default: pattern = 8'b11101110;
				endcase
			end
		end else if (rate[5:2] == 4'd0 && !attack) begin
			pattern = 8'b11111110; // slowest decay
		end else begin
			case (rate[1:0])
				2'd0: pattern = 8'b10101010;
				2'd1: pattern = 8'b11101010;
				2'd2: pattern = 8'b11101110;
				default: pattern = 8'b11111110;
			endcase
		end
		step = (rate[5:1] == '0) ? 1'b0 : pattern[cnt_win];
	end

	// above 47 every tick moves, the pattern only doubles the size
	assign step_en = tick && (rate[5:4] == 2'b11 || step);

	always_comb begin
		case (rate[5:2])
			4'd12: step_size = step ? 4'd2 : 4'd1;
			4'd13: step_size = step ? 4'd4 : 4'd2;
			4'd14: step_size = step ? 4'd8 : 4'd4;
			4'd15: step_size = 4'd8;
			default: step_size = attack ? 4'd1 : 4'd2;
		endcase
		if (attack && rate[5:1] == 5'd31)
			step_size = STEP_FULL;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_SLOTS; i++)
				cnt_last[i] <= 1'b0;
		end else begin
			cnt_last[p1_slot] <= cnt_win[0];
		end
	end

endmodule

`default_nettype wire

/* eg_regs.sv */
// Wishbone classic slave for the per-slot settings
// address is slot*8 + offset, ack lasts one cycle and never back to back
// writes land on the edge that raises ack, read data is valid while ack is high
// REG_OUT is read only, unused bits read 0
`timescale 1ns/1ns
`default_nettype none

module eg_regs import eg_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic                cyc,
	input  logic                stb,
	input  logic                we,
	input  logic [WB_ADR_W-1:0] adr,
	input  logic [WB_DAT_W-1:0] dat_w,
	output logic [WB_DAT_W-1:0] dat_r,
	output logic                ack,
	input  logic [SLOT_W-1:0]   slot,
	output logic [4:0]          keycode,
	output logic [1:0]          ks,
	output logic [4:0]          arate,
	output logic [4:0]          rate1,
	output logic [4:0]          rate2,
	output logic [3:0]          rrate,
	output logic [3:0]          d1l,
	output logic [6:0]          tl,
	output logic                keyon,
	output logic [SLOT_W-1:0]   out_sel,
	input  logic [LVL_W-1:0]    out_val
);

	logic [4:0] keycode_mem [NUM_SLOTS];
	logic [1:0] ks_mem      [NUM_SLOTS];
	logic [4:0] arate_mem   [NUM_SLOTS];
	logic [4:0] rate1_mem   [NUM_SLOTS];
	logic [4:0] rate2_mem   [NUM_SLOTS];
	logic [3:0] rrate_mem   [NUM_SLOTS];
	logic [3:0] d1l_mem     [NUM_SLOTS];
	logic [6:0] tl_mem      [NUM_SLOTS];
	logic       keyon_mem   [NUM_SLOTS];

	logic                req;
	logic [SLOT_W-1:0]   bus_slot;
	eg_reg_t             reg_sel;
	logic [WB_DAT_W-1:0] rd_data;

	assign req      = cyc && stb && !ack; // first cycle of a transfer
	assign bus_slot = adr[WB_ADR_W-1:3];
	assign reg_sel  = eg_reg_t'(adr[2:0]);
	assign out_sel  = bus_slot;

	// settings of the slot under control, combinational
	assign keycode = keycode_mem[slot];
	assign ks      = ks_mem[slot];
	assign arate   = arate_mem[slot];
	assign rate1   = rate1_mem[slot];
	assign rate2   = rate2_mem[slot];
	assign rrate   = rrate_mem[slot];
	assign d1l     = d1l_mem[slot];
	assign tl      = tl_mem[slot];
	assign keyon   = keyon_mem[slot];

	always_ff @(posedge clk) begin
		if (rst) begin
			ack <= 1'b0;
			for (int i = 0; i < NUM_SLOTS; i++) begin
				keycode_mem[i] <= '0;
				ks_mem[i]      <= '0;
				arate_mem[i]   <= '0;
				rate1_mem[i]   <= '0;
				rate2_mem[i]   <= '0;
				rrate_mem[i]   <= '0;
				d1l_mem[i]     <= '0;
				tl_mem[i]      <= '0;
				keyon_mem[i]   <= 1'b0;
			end
		end else begin
			ack <= req;
			if (req && we) begin
				case (reg_sel)
					REG_KEYCODE: begin
						keycode_mem[bus_slot] <= dat_w[4:0];
						ks_mem[bus_slot]      <= dat_w[6:5];
					end
					REG_ARATE: arate_mem[bus_slot] <= dat_w[4:0];
					REG_RATE1: rate1_mem[bus_slot] <= dat_w[4:0];
					REG_RATE2: rate2_mem[bus_slot] <= dat_w[4:0];
					REG_RREL: begin
						rrate_mem[bus_slot] <= dat_w[3:0];
						d1l_mem[bus_slot]   <= dat_w[7:4];
					end
					REG_TL:    tl_mem[bus_slot]    <= dat_w[6:0];
					REG_KEYON: keyon_mem[bus_slot] <= dat_w[0];
					default: ; // REG_OUT ignores writes
				endcase
			end
		end
	end

	always_comb begin
		rd_data = '0;
		case (reg_sel)
			REG_KEYCODE: rd_data[6:0] = {ks_mem[bus_slot], keycode_mem[bus_slot]};
			REG_ARATE:   rd_data[4:0] = arate_mem[bus_slot];
			REG_RATE1:   rd_data[4:0] = rate1_mem[bus_slot];
			REG_RATE2:   rd_data[4:0] = rate2_mem[bus_slot];
			REG_RREL:    rd_data[7:0] = {d1l_mem[bus_slot], rrate_mem[bus_slot]};
			REG_TL:      rd_data[6:0] = tl_mem[bus_slot];
			REG_KEYON:   rd_data[0]   = keyon_mem[bus_slot];
			REG_OUT:     rd_data[LVL_W-1:0] = out_val;
		endcase
	end

	always_ff @(posedge clk) begin
		if (req) begin
			dat_r <= rd_data; // held through the ack cycle
		end
	end

	// ack answers a request seen on the previous edge
	a_ack_follows_req: assert property (@(posedge clk) disable iff (rst)
		ack |-> $past(cyc && stb && !ack));

endmodule

`default_nettype wire

/* eg_top.sv */
// eight-slot envelope generator with a Wishbone classic host port
// rotation never stalls, only the host waits for ack
// a settings write shows on REG_OUT within 16 cycles
`timescale 1ns/1ns
`default_nettype none

module eg_top import eg_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic                cyc,
	input  logic                stb,
	input  logic                we,
	input  logic [WB_ADR_W-1:0] adr,
	input  logic [WB_DAT_W-1:0] dat_w,
	output logic [WB_DAT_W-1:0] dat_r,
	output logic                ack
);

	logic [4:0]          keycode;
	logic [1:0]          ks;
	logic [4:0]          arate;
	logic [4:0]          rate1;
	logic [4:0]          rate2;
	logic [3:0]          rrate;
	logic [3:0]          d1l;
	logic [6:0]          tl;
	logic                keyon;
	logic [SLOT_W-1:0]   slot;
	logic [SLOT_W-1:0]   out_sel;
	logic [LVL_W-1:0]    out_val;
	logic [LVL_W-1:0]    level_now;
	logic [LVL_W-1:0]    level_new;
	logic [SLOT_W-1:0]   p1_slot;
	eg_phase_t           p1_phase;
	logic [4:0]          p1_cfg;
	logic [4:0]          p1_keycode;
	logic [1:0]          p1_ks;
	logic                p1_instant;
	logic [6:0]          p1_tl;
	logic [EG_CNT_W-1:0] eg_cnt;
	logic                step_en;
	logic [STEP_W-1:0]   step_size;

	eg_regs u_regs (
		.clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.dat_w(dat_w), .dat_r(dat_r), .ack(ack), .slot(slot),
		.keycode(keycode), .ks(ks), .arate(arate), .rate1(rate1), .rate2(rate2),
		.rrate(rrate), .d1l(d1l), .tl(tl), .keyon(keyon),
		.out_sel(out_sel), .out_val(out_val)
	);

	eg_ctrl u_ctrl (
		.clk(clk), .rst(rst), .keycode(keycode), .ks(ks), .arate(arate),
		.rate1(rate1), .rate2(rate2), .rrate(rrate), .d1l(d1l), .tl(tl),
		.keyon(keyon), .level_now(level_now), .slot(slot), .p1_slot(p1_slot),
		.p1_phase(p1_phase), .p1_cfg(p1_cfg), .p1_keycode(p1_keycode),
		.p1_ks(p1_ks), .p1_instant(p1_instant), .p1_tl(p1_tl), .eg_cnt(eg_cnt)
	);

	eg_rate u_rate (
		.clk(clk), .rst(rst), .p1_slot(p1_slot), .p1_phase(p1_phase),
		.p1_cfg(p1_cfg), .p1_keycode(p1_keycode), .p1_ks(p1_ks), .eg_cnt(eg_cnt),
		.step_en(step_en), .step_size(step_size)
	);

	eg_level u_level (
		.clk(clk), .rst(rst), .p1_slot(p1_slot), .p1_phase(p1_phase),
		.p1_instant(p1_instant), .step_en(step_en), .step_size(step_size),
		.slot(slot), .level_now(level_now), .level_new(level_new)
	);

	eg_atten u_atten (
		.clk(clk), .rst(rst), .p1_slot(p1_slot), .p1_tl(p1_tl),
		.level_new(level_new), .out_sel(out_sel), .out_val(out_val)
	);

endmodule

`default_nettype wire

/* tb_eg.sv */
// testbench for the eight-slot envelope generator
// stimulus rows are applied in order, slots picked by a seeded LCG shuffle
// polling paces one REG_OUT read per slot rotation (8 cycles)
// stops at the first mismatch, cycle limit is 1.5x the summed row waits
`timescale 1ns/1ns
`default_nettype none

module tb_eg import eg_pkg::*;;

	typedef enum int {EXACT, SETTLE, RISE, HOLD} check_mode_t;

	localparam int NROWS = 7;
	localparam int ROT   = NUM_SLOTS; // cycles per rotation

	logic                clk;
	logic                rst;
	logic                cyc;
	logic                stb;
	logic                we;
	logic [WB_ADR_W-1:0] adr;
	logic [WB_DAT_W-1:0] dat_w;
	logic [WB_DAT_W-1:0] dat_r;
	logic                ack;

	logic [31:0] seed = 32'h2724;
	int          cycles = 0;
	int          timeout_limit;
	int          perm [NUM_SLOTS];
	int          held [NUM_SLOTS]; // last known REG_OUT per slot

	// stimulus and expected values, one entry per row
	string       row_name [NROWS];
	int          row_slot [NROWS]; // index into perm
	int          row_kc   [NROWS]; // ks and keycode as written
	int          row_ar   [NROWS];
	int          row_r1   [NROWS];
	int          row_r2   [NROWS];
	int          row_rrel [NROWS];
	int          row_tl   [NROWS];
	int          row_key  [NROWS];
	int          row_wait [NROWS]; // rotations, or poll limit
	int          row_exp  [NROWS];
	check_mode_t row_mode [NROWS];

	// register width masks, offsets 0 to 6
	int reg_mask [7] = '{'h7f, 'h1f, 'h1f, 'h1f, 'hff, 'h7f, 'h01};

	eg_top dut_i (
		.clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.dat_w(dat_w), .dat_r(dat_r), .ack(ack)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_limit) begin
			$display("timeout, run went past %0d cycles without finishing", timeout_limit);
			$display("Testbench failed");
			$fatal(1, "cycle limit reached");
		end
	end

	function automatic logic [31:0] rand_next();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	function automatic int reg_addr(input int s, input int off);
		return s * 8 + off;
	endfunction

	// sustain point in level units, top d1l step counts as 16
	function automatic int sustain_out(input int d1l);
		return (d1l == 15) ? 512 : 32 * d1l;
	endfunction

	task automatic check(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("ERR %s: expected %0d, actual %0d", name, expected, actual);
			$display("Testbench failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	task automatic wb_write(input int a, input int data);
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = 1'b1;
		adr   = WB_ADR_W'(a);
		dat_w = WB_DAT_W'(data);
		do begin
			@(posedge clk);
			#2;
		end while (!ack); // ack from the previous transfer is skipped
		cyc = 1'b0;
		stb = 1'b0;
		we  = 1'b0;
	endtask

	task automatic wb_read(input int a, output int data);
		cyc = 1'b1;
		stb = 1'b1;
		we  = 1'b0;
		adr = WB_ADR_W'(a);
		do begin
			@(posedge clk);
			#2;
		end while (!ack);
		data = int'(dat_r);
		cyc = 1'b0;
		stb = 1'b0;
	endtask

	// one REG_OUT read padded out to a full rotation
	task automatic sample_rotation(input int s, output int val);
		int t0;
		t0 = cycles;
		wb_read(reg_addr(s, REG_OUT), val);
		while (cycles < t0 + ROT) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic set_row(input int i, input string name, input int sl, input int kc,
			input int ar, input int r1, input int r2, input int rrel, input int tl,
			input int key, input int wt, input int exp, input check_mode_t mode);
		row_name[i] = name;
		row_slot[i] = sl;
		row_kc[i]   = kc;
		row_ar[i]   = ar;
		row_r1[i]   = r1;
		row_r2[i]   = r2;
		row_rrel[i] = rrel;
		row_tl[i]   = tl;
		row_key[i]  = key;
		row_wait[i] = wt;
		row_exp[i]  = exp;
		row_mode[i] = mode;
	endtask

	task automatic build_table();
		int tl_r;
		tl_r = int'((rand_next() >> 16) & 32'h7f);
		set_row(0, "instant_attack", 0, 'h00, 31, 0, 0, 'h00, 0, 1, 2, 0, EXACT);
		set_row(1, "instant_tl_rand", 1, 'h00, 31, 0, 0, 'h00, tl_r, 1, 2,
			(8 * tl_r > 1023) ? 1023 : 8 * tl_r, EXACT);
		set_row(2, "instant_tl_max", 2, 'h00, 31, 0, 0, 'h00, 127, 1, 2, 1016, EXACT);
		set_row(3, "sustain_d1l_6", 3, 'h7f, 31, 31, 0, 'h6f, 0, 1, 90,
			sustain_out(6), SETTLE);
		set_row(4, "sustain_d1l_15", 4, 'h7f, 31, 31, 0, 'hff, 0, 1, 210,
			sustain_out(15), SETTLE);
		set_row(5, "release", 4, 'h7f, 31, 31, 0, 'hff, 0, 0, 210, 1023, RISE);
		set_row(6, "hold_rates_zero", 5, 'h00, 0, 0, 0, 'h00, 0, 1, 20, 1023, HOLD);
	endtask

	initial begin
		int r, s, n, val, prev, j, tmp, sum, data;
		rst   = 1'b1;
		cyc   = 1'b0;
		stb   = 1'b0;
		we    = 1'b0;
		adr   = '0;
		dat_w = '0;

		for (int i = 0; i < NUM_SLOTS; i++) begin
			perm[i] = i;
			held[i] = 1023;
		end
		for (int i = NUM_SLOTS - 1; i > 0; i--) begin
			j = int'((rand_next() >> 16) % (i + 1));
			tmp = perm[i];
			perm[i] = perm[j];
			perm[j] = tmp;
		end
		build_table();
		sum = 0;
		for (int i = 0; i < NROWS; i++)
			sum += row_wait[i];
		timeout_limit = sum * ROT * 3 / 2;

		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;

		// every output silent after reset
		for (int i = 0; i < NUM_SLOTS; i++) begin
			wb_read(reg_addr(i, REG_OUT), val);
			check($sformatf("reset_out_slot%0d", i), 1023, val);
		end

		// readback masking on the slot no row uses, key-on bit kept low
		s = perm[NUM_SLOTS - 1];
		for (int k = 0; k < 7; k++) begin
			data = int'(rand_next() >> 16);
			if (k == int'(REG_KEYON))
				data = data & 'hfffe;
			wb_write(reg_addr(s, k), data);
			wb_read(reg_addr(s, k), val);
			check($sformatf("readback_off%0d", k), data & reg_mask[k], val);
		end
		wb_write(reg_addr(s, REG_OUT), int'(rand_next() >> 16));
		wb_read(reg_addr(s, REG_OUT), val);
		check("out_write_ignored", 1023, val);
		for (int k = 0; k < 7; k++)
			wb_write(reg_addr(s, k), 0);

		for (r = 0; r < NROWS; r++) begin
			s = perm[row_slot[r]];
			wb_write(reg_addr(s, REG_KEYCODE), row_kc[r]);
			wb_write(reg_addr(s, REG_ARATE), row_ar[r]);
			wb_write(reg_addr(s, REG_RATE1), row_r1[r]);
			wb_write(reg_addr(s, REG_RATE2), row_r2[r]);
			wb_write(reg_addr(s, REG_RREL), row_rrel[r]);
			wb_write(reg_addr(s, REG_TL), row_tl[r]);
			wb_write(reg_addr(s, REG_KEYON), row_key[r]);
			wb_read(reg_addr(s, REG_KEYON), val);
			check({row_name[r], "_keyon"}, row_key[r], val);

			case (row_mode[r])
				EXACT: begin
					wait_cycles(row_wait[r] * ROT);
					wb_read(reg_addr(s, REG_OUT), val);
					check(row_name[r], row_exp[r], val);
				end
				SETTLE: begin
					n = 0;
					do begin
						sample_rotation(s, val);
						n++;
					end while (val != row_exp[r] && n < row_wait[r]);
					check(row_name[r], row_exp[r], val);
					repeat (10) begin
						sample_rotation(s, val);
						check({row_name[r], "_stay"}, row_exp[r], val);
					end
				end
				RISE: begin
					prev = held[s];
					n = 0;
					do begin
						sample_rotation(s, val);
						if (val < prev)
							check({row_name[r], "_rising"}, prev, val);
						prev = val;
						n++;
					end while (val != row_exp[r] && n < row_wait[r]);
					check(row_name[r], row_exp[r], val);
				end
				default: begin
					repeat (row_wait[r]) begin
						sample_rotation(s, val);
						check(row_name[r], row_exp[r], val);
					end
				end
			endcase
			held[s] = row_exp[r];

			// the other slots must not have moved
			for (int q = 0; q < NUM_SLOTS; q++) begin
				if (q != s) begin
					wb_read(reg_addr(q, REG_OUT), val);
					check($sformatf("%s_keep_slot%0d", row_name[r], q), held[q], val);
				end
			end
		end

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
eg_pkg.sv
eg_regs.sv
eg_ctrl.sv
eg_rate.sv
eg_level.sv
eg_atten.sv
eg_top.sv
tb_eg.sv
